// ==== run.sh ====
#!/bin/sh
# Builds the histogram testbench with Verilator, runs it and decides
# pass or fail from the simulation log.

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
    -f src.f --top-module histogram_tb -o sim_histogram
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/sim_histogram > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "^Test passed$" sim.log; then
    exit 0
fi
exit 1

// ==== src.f ====
src/hist_pkg.sv
src/hist_ctrl.sv
src/tag_diff.sv
src/hist_bank.sv
src/hist_readout.sv
src/histogram_top.sv
tb/tb_clock.sv
tb/histogram_sva.sv
tb/histogram_tb.sv

// ==== src/hist_bank.sv ====
// Histogram bank
// One lane memory of one ping-pong buffer. On the gathering side it
// increments bins with a read-modify-write, on the read side it returns
// each count and writes zero, and clr zeroes a bin silently.

`timescale 1ns/1ps

module hist_bank #(
    parameter int BANK_ID = 0
) (
    input  logic                                 clk,
    input  logic [hist_pkg::HIST_ADDR_WIDTH-1:0] bin,
    input  logic                                 bin_valid,
    input  logic                                 read_bank,
    input  logic [hist_pkg::HIST_ADDR_WIDTH-1:0] rd_addr,
    input  logic                                 rd_en,
    input  logic                                 clr,
    output logic [hist_pkg::HIST_WORD-1:0]       count,
    output logic                                 count_valid
);

    logic [hist_pkg::HIST_WORD-1:0] mem [hist_pkg::HIST_DEPTH];
    logic read_side;
    logic [hist_pkg::HIST_ADDR_WIDTH-1:0] addr;
    logic s1_inc;
    logic s1_rd;
    logic s1_clr;
    logic s1_we;
    logic [hist_pkg::HIST_ADDR_WIDTH-1:0] s1_addr;
    logic [hist_pkg::HIST_WORD-1:0] s1_rdata;
    logic [hist_pkg::HIST_WORD-1:0] cur;
    logic [hist_pkg::HIST_WORD-1:0] wr_data;
    logic fwd_vld;
    logic [hist_pkg::HIST_ADDR_WIDTH-1:0] fwd_addr;
    logic [hist_pkg::HIST_WORD-1:0] fwd_data;

    // this bank is drained when the controller points read_bank at it
    assign read_side = (read_bank == 1'(BANK_ID));
    assign addr = (clr || read_side) ? rd_addr : bin;

    // the memory read lands one cycle after the address, so a write to the
    // same bin on the previous edge is taken from the forward register
    assign cur = (fwd_vld && (fwd_addr == s1_addr)) ? fwd_data : s1_rdata;

    // reads and clears both leave zero behind
    assign wr_data = s1_inc ? cur + 1'b1 : '0;
    assign s1_we = s1_inc || s1_rd || s1_clr;

    always_ff @(posedge clk) begin
        s1_rdata <= mem[addr];
        s1_addr <= addr;
        s1_clr <= clr;
        s1_rd <= read_side && rd_en && !clr;
        s1_inc <= !read_side && bin_valid && !clr;
        if (s1_we) begin
            mem[s1_addr] <= wr_data;
        end
    end

    always_ff @(posedge clk) begin
        fwd_vld <= s1_we;
        fwd_addr <= s1_addr;
        fwd_data <= wr_data;
        count <= cur;
        count_valid <= s1_rd;
    end

endmodule

// ==== src/hist_ctrl.sv ====
// Histogram controller
// Sweeps every bin clear after reset, latches the channel and shift
// configuration once, swaps the ping-pong buffers on a read request and
// generates the read-and-clear addresses under read_en.

`timescale 1ns/1ps

module hist_ctrl (
    input  logic                                clk,
    input  logic                                rst,
    input  logic                                config_en,
    input  logic [hist_pkg::CHANNEL_WIDTH-1:0]  start_channel,
    input  logic [hist_pkg::CHANNEL_WIDTH-1:0]  click_channel,
    input  logic [hist_pkg::SHIFT_WIDTH-1:0]    shift_val,
    input  logic                                read_start,
    input  logic                                read_en,
    output logic                                gather_en,
    output logic [hist_pkg::CHANNEL_WIDTH-1:0]  start_ch_q,
    output logic [hist_pkg::CHANNEL_WIDTH-1:0]  click_ch_q,
    output logic [hist_pkg::SHIFT_WIDTH-1:0]    shift_q,
    output logic                                read_bank,
    output logic [hist_pkg::HIST_ADDR_WIDTH-1:0] rd_addr,
    output logic                                rd_en,
    output logic                                rd_last,
    output logic                                clr
);

    logic [1:0] state;
    logic config_en_q;
    logic read_start_q;
    logic config_edge;
    logic read_edge;
    logic addr_last;
    logic [hist_pkg::HIST_ADDR_WIDTH-1:0] addr_cnt;
    logic [hist_pkg::DRAIN_WIDTH-1:0] drain_cnt;

    // only rising edges of the two request inputs count
    assign config_edge = config_en && !config_en_q;
    assign read_edge = read_start && !read_start_q;
    assign addr_last = (addr_cnt == hist_pkg::HIST_ADDR_WIDTH'(hist_pkg::HIST_DEPTH - 1));

    // tags are taken while gathering and also while the other buffer is read
    assign gather_en = (state == hist_pkg::ST_GATHER) || (state == hist_pkg::ST_READ);

    always_ff @(posedge clk) begin
        config_en_q <= config_en;
        read_start_q <= read_start;
        rd_en <= 1'b0;
        rd_last <= 1'b0;
        clr <= 1'b0;
        if (rst) begin
            state <= hist_pkg::ST_CLEARING;
            addr_cnt <= '0;
            drain_cnt <= '0;
            read_bank <= 1'b0;
            config_en_q <= 1'b0;
            read_start_q <= 1'b0;
        end else begin
            case (state)
                hist_pkg::ST_CLEARING: begin
                    // one address per cycle, all four banks write zero
                    clr <= 1'b1;
                    rd_addr <= addr_cnt;
                    addr_cnt <= addr_cnt + 1'b1;
                    if (addr_last) begin
                        state <= hist_pkg::ST_WAIT_CONFIG;
                    end
                end
                hist_pkg::ST_WAIT_CONFIG: begin
                    if (config_edge) begin
                        start_ch_q <= start_channel;
                        click_ch_q <= click_channel;
                        shift_q <= shift_val;
                        state <= hist_pkg::ST_GATHER;
                    end
                end
                hist_pkg::ST_GATHER: begin
                    // the filled buffer becomes the read side right away,
                    // new tags go to the other one
                    if (read_edge) begin
                        read_bank <= ~read_bank;
                        drain_cnt <= hist_pkg::DRAIN_WIDTH'(hist_pkg::DRAIN_DELAY);
                        state <= hist_pkg::ST_READ;
                    end
                end
                hist_pkg::ST_READ: begin
                    // wait for increments still in the bank pipelines
                    if (drain_cnt != '0) begin
                        drain_cnt <= drain_cnt - 1'b1;
                    end else if (read_en) begin
                        rd_en <= 1'b1;
                        rd_addr <= addr_cnt;
                        rd_last <= addr_last;
                        addr_cnt <= addr_cnt + 1'b1;
                        if (addr_last) begin
                            state <= hist_pkg::ST_GATHER;
                        end
                    end
                end
                default: begin
                    state <= hist_pkg::ST_CLEARING;
                end
            endcase
        end
    end

endmodule

// ==== src/hist_pkg.sv ====
// Histogram package
// Shared widths, depths and pipeline latencies of the start-stop
// time-difference histogram, plus the controller state encoding.

package hist_pkg;

    // tag stream shape, two tags arrive on every clock
    localparam int NUM_TAGS = 2;
    localparam int TAG_WIDTH = 32;
    localparam int CHANNEL_WIDTH = 4;
    localparam int SHIFT_WIDTH = 5;

    // bin memory shape, the top bin also collects overflow
    localparam int HIST_DEPTH = 64;
    localparam int HIST_ADDR_WIDTH = 6;
    localparam int HIST_WORD = 16;

    // cycles given to in-flight increments after a buffer swap
    localparam int DRAIN_DELAY = 8;
    localparam int DRAIN_WIDTH = $clog2(DRAIN_DELAY + 1);

    // address register, bank latency and two readout registers
    localparam int BANK_LATENCY = 2;
    localparam int READ_LATENCY = 1 + BANK_LATENCY + 2;

    // controller states
    localparam logic [1:0] ST_CLEARING = 2'd0;
    localparam logic [1:0] ST_WAIT_CONFIG = 2'd1;
    localparam logic [1:0] ST_GATHER = 2'd2;
    localparam logic [1:0] ST_READ = 2'd3;

endpackage

// ==== src/hist_readout.sv ====
// Histogram readout
// Picks the lanes of the buffer being drained, sums them per bin and
// lines the last flag up with the final count before the output registers.

`timescale 1ns/1ps

module hist_readout (
    input  logic                                                 clk,
    input  logic                                                 rst,
    input  logic [hist_pkg::NUM_TAGS*hist_pkg::HIST_WORD-1:0]    count_b0,
    input  logic [hist_pkg::NUM_TAGS-1:0]                        valid_b0,
    input  logic [hist_pkg::NUM_TAGS*hist_pkg::HIST_WORD-1:0]    count_b1,
    input  logic [hist_pkg::NUM_TAGS-1:0]                        valid_b1,
    input  logic                                                 read_bank,
    input  logic                                                 rd_last,
    output logic [hist_pkg::HIST_WORD-1:0]                       data_out,
    output logic                                                 valid_out,
    output logic                                                 last_out
);

    localparam int HW = hist_pkg::HIST_WORD;
    localparam int BL = hist_pkg::BANK_LATENCY;

    logic [BL-1:0] last_dly;
    logic [BL-1:0] bank_dly;
    logic [hist_pkg::NUM_TAGS*HW-1:0] lanes_q;
    logic valid_q;
    logic last_q;
    logic [HW-1:0] sum;

    always_comb begin
        sum = '0;
        for (int i = 0; i < hist_pkg::NUM_TAGS; i++) begin
            sum = sum + lanes_q[i*HW +: HW];
        end
    end

    always_ff @(posedge clk) begin
        // the bank select travels with the request so a swap right after the
        // last address cannot redirect counts still in the banks
        lanes_q <= bank_dly[BL-1] ? count_b1 : count_b0;
        data_out <= sum;
        if (rst) begin
            last_dly <= '0;
            bank_dly <= '0;
            valid_q <= 1'b0;
            last_q <= 1'b0;
            valid_out <= 1'b0;
            last_out <= 1'b0;
        end else begin
            last_dly <= {last_dly[BL-2:0], rd_last};
            bank_dly <= {bank_dly[BL-2:0], read_bank};
            valid_q <= bank_dly[BL-1] ? |valid_b1 : |valid_b0;
            last_q <= last_dly[BL-1];
            valid_out <= valid_q;
            last_out <= last_q;
        end
    end

endmodule

// ==== src/histogram_top.sv ====
// Start-stop histogram top level
// Connects the controller, the tag difference stage, two ping-pong buffers
// of one bank per lane each, and the summing readout.

`timescale 1ns/1ps

module histogram_top (
    input  logic                                                  clk,
    input  logic                                                  rst,
    input  logic [hist_pkg::NUM_TAGS*hist_pkg::TAG_WIDTH-1:0]     tagtime,
    input  logic [hist_pkg::NUM_TAGS*hist_pkg::CHANNEL_WIDTH-1:0] channel,
    input  logic [hist_pkg::NUM_TAGS-1:0]                         valid_tag,
    input  logic                                                  config_en,
    input  logic [hist_pkg::CHANNEL_WIDTH-1:0]                    start_channel,
    input  logic [hist_pkg::CHANNEL_WIDTH-1:0]                    click_channel,
    input  logic [hist_pkg::SHIFT_WIDTH-1:0]                      shift_val,
    input  logic                                                  read_start,
    input  logic                                                  read_en,
    output logic [hist_pkg::HIST_WORD-1:0]                        data_out,
    output logic                                                  valid_out,
    output logic                                                  last_out
);

    localparam int AW = hist_pkg::HIST_ADDR_WIDTH;
    localparam int HW = hist_pkg::HIST_WORD;

    logic gather_en;
    logic [hist_pkg::CHANNEL_WIDTH-1:0] start_ch_q;
    logic [hist_pkg::CHANNEL_WIDTH-1:0] click_ch_q;
    logic [hist_pkg::SHIFT_WIDTH-1:0] shift_q;
    logic read_bank;
    logic [AW-1:0] rd_addr;
    logic rd_en;
    logic rd_last;
    logic clr;
    logic [hist_pkg::NUM_TAGS*AW-1:0] bin;
    logic [hist_pkg::NUM_TAGS-1:0] bin_valid;
    logic [hist_pkg::NUM_TAGS*HW-1:0] count_bk [2];
    logic [hist_pkg::NUM_TAGS-1:0] valid_bk [2];

    hist_ctrl i_ctrl (
        .clk(clk), .rst(rst), .config_en(config_en),
        .start_channel(start_channel), .click_channel(click_channel),
        .shift_val(shift_val), .read_start(read_start), .read_en(read_en),
        .gather_en(gather_en), .start_ch_q(start_ch_q), .click_ch_q(click_ch_q),
        .shift_q(shift_q), .read_bank(read_bank), .rd_addr(rd_addr),
        .rd_en(rd_en), .rd_last(rd_last), .clr(clr)
    );

    tag_diff i_tag_diff (
        .clk(clk), .rst(rst), .tagtime(tagtime), .channel(channel),
        .valid_tag(valid_tag), .gather_en(gather_en), .start_ch_q(start_ch_q),
        .click_ch_q(click_ch_q), .shift_q(shift_q), .bin(bin), .bin_valid(bin_valid)
    );

    // every lane writes into both buffers, read_bank decides which one listens
    for (genvar b = 0; b < 2; b++) begin : g_buf
        for (genvar l = 0; l < hist_pkg::NUM_TAGS; l++) begin : g_lane
            hist_bank #(.BANK_ID(b)) i_bank (
                .clk(clk), .bin(bin[l*AW +: AW]), .bin_valid(bin_valid[l]),
                .read_bank(read_bank), .rd_addr(rd_addr), .rd_en(rd_en), .clr(clr),
                .count(count_bk[b][l*HW +: HW]), .count_valid(valid_bk[b][l])
            );
        end
    end

    hist_readout i_readout (
        .clk(clk), .rst(rst), .count_b0(count_bk[0]), .valid_b0(valid_bk[0]),
        .count_b1(count_bk[1]), .valid_b1(valid_bk[1]), .read_bank(read_bank),
        .rd_last(rd_last), .data_out(data_out), .valid_out(valid_out),
        .last_out(last_out)
    );

endmodule

// ==== src/tag_diff.sv ====
// Tag difference stage
// Registers the tag stream, tracks the latest start-channel timestamp and
// turns each following click into a saturated histogram bin, lane 0 first.

`timescale 1ns/1ps

module tag_diff (
    input  logic                                                  clk,
    input  logic                                                  rst,
    input  logic [hist_pkg::NUM_TAGS*hist_pkg::TAG_WIDTH-1:0]     tagtime,
    input  logic [hist_pkg::NUM_TAGS*hist_pkg::CHANNEL_WIDTH-1:0] channel,
    input  logic [hist_pkg::NUM_TAGS-1:0]                         valid_tag,
    input  logic                                                  gather_en,
    input  logic [hist_pkg::CHANNEL_WIDTH-1:0]                    start_ch_q,
    input  logic [hist_pkg::CHANNEL_WIDTH-1:0]                    click_ch_q,
    input  logic [hist_pkg::SHIFT_WIDTH-1:0]                      shift_q,
    output logic [hist_pkg::NUM_TAGS*hist_pkg::HIST_ADDR_WIDTH-1:0] bin,
    output logic [hist_pkg::NUM_TAGS-1:0]                         bin_valid
);

    localparam int TW = hist_pkg::TAG_WIDTH;
    localparam int CW = hist_pkg::CHANNEL_WIDTH;
    localparam int AW = hist_pkg::HIST_ADDR_WIDTH;

    logic [hist_pkg::NUM_TAGS*TW-1:0] tag_q;
    logic [hist_pkg::NUM_TAGS*CW-1:0] ch_q;
    logic [hist_pkg::NUM_TAGS-1:0] vld_q;
    logic started;
    logic started_nxt;
    logic [TW-1:0] start_time;
    logic [TW-1:0] start_nxt;
    logic [TW-1:0] diff;
    logic [TW-1:0] shifted;
    logic [hist_pkg::NUM_TAGS*AW-1:0] bin_nxt;
    logic [hist_pkg::NUM_TAGS-1:0] hit_nxt;

    // a start in lane 0 is already visible to a click in lane 1
    always_comb begin
        started_nxt = started;
        start_nxt = start_time;
        hit_nxt = '0;
        bin_nxt = '0;
        diff = '0;
        shifted = '0;
        for (int i = 0; i < hist_pkg::NUM_TAGS; i++) begin
            if (vld_q[i] && (ch_q[i*CW +: CW] == start_ch_q)) begin
                started_nxt = 1'b1;
                start_nxt = tag_q[i*TW +: TW];
            end
            // clicks before the first start are dropped
            if (vld_q[i] && (ch_q[i*CW +: CW] == click_ch_q) && started_nxt) begin
                diff = tag_q[i*TW +: TW] - start_nxt;
                shifted = diff >> shift_q;
                hit_nxt[i] = 1'b1;
                if (shifted >= TW'(hist_pkg::HIST_DEPTH)) begin
                    bin_nxt[i*AW +: AW] = AW'(hist_pkg::HIST_DEPTH - 1);
                end else begin
                    bin_nxt[i*AW +: AW] = shifted[AW-1:0];
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        tag_q <= tagtime;
        ch_q <= channel;
        bin <= bin_nxt;
        if (rst) begin
            vld_q <= '0;
            started <= 1'b0;
            start_time <= '0;
            bin_valid <= '0;
        end else begin
            // tags outside gathering never reach the difference logic
            vld_q <= valid_tag & {hist_pkg::NUM_TAGS{gather_en}};
            started <= started_nxt;
            start_time <= start_nxt;
            bin_valid <= hit_nxt;
        end
    end

endmodule

// ==== tb/histogram_sva.sv ====
// Histogram handshake assertions
// Bound into the histogram top level to watch the read pipeline and the
// output flags.

`timescale 1ns/1ps

module histogram_sva (
    input logic                           clk,
    input logic                           rst,
    input logic                           rd_en,
    input logic [hist_pkg::HIST_WORD-1:0] data_out,
    input logic                           valid_out,
    input logic                           last_out
);

    // rd_en is the accepted read_en one cycle later, so the rest of the
    // read latency lies between it and valid_out
    localparam int ADDR_TO_OUT = hist_pkg::READ_LATENCY - 1;

    // the comparison starts once the whole latency window lies after reset
    a_read_to_valid: assert property (@(posedge clk) disable iff (rst)
        $past(!rst, ADDR_TO_OUT) |-> (valid_out == $past(rd_en, ADDR_TO_OUT)))
        else $error("valid_out does not follow read_en by READ_LATENCY cycles");

    a_last_with_valid: assert property (@(posedge clk) disable iff (rst)
        last_out |-> valid_out)
        else $error("last_out seen without valid_out");

    a_reset_quiet: assert property (@(posedge clk)
        rst |=> (!valid_out && !last_out))
        else $error("valid_out or last_out high right after reset");

    a_data_known: assert property (@(posedge clk) disable iff (rst)
        valid_out |-> !$isunknown(data_out))
        else $error("data_out unknown while valid_out is high");

endmodule

bind histogram_top histogram_sva i_sva (
    .clk(clk),
    .rst(rst),
    .rd_en(rd_en),
    .data_out(data_out),
    .valid_out(valid_out),
    .last_out(last_out)
);

// ==== tb/histogram_tb.sv ====
// Histogram testbench
// Drives a table of configuration, tag and read entries into the histogram,
// keeps a reference histogram of the bin rule and checks every streamed bin
// against it, in address order, with the last flag on the final bin only.

`timescale 1ns/1ps

module histogram_tb;

    localparam int NT = hist_pkg::NUM_TAGS;
    localparam int TW = hist_pkg::TAG_WIDTH;
    localparam int CW = hist_pkg::CHANNEL_WIDTH;
    localparam int HW = hist_pkg::HIST_WORD;
    localparam int DEPTH = hist_pkg::HIST_DEPTH;

    // kinds of table entry, a read entry carries its read_en mode in t0
    localparam int K_TAG = 0;
    localparam int K_CFG = 1;
    localparam int K_READ = 2;
    localparam int K_WAIT = 3;

    typedef struct {
        int kind;
        int gap;
        logic [NT-1:0] vld;
        logic [CW-1:0] ch0;
        logic [TW-1:0] t0;
        logic [CW-1:0] ch1;
        logic [TW-1:0] t1;
        string name;
    } entry_t;

    logic clk;
    logic rst;
    logic [NT*TW-1:0] tagtime;
    logic [NT*CW-1:0] channel;
    logic [NT-1:0] valid_tag;
    logic config_en;
    logic [CW-1:0] start_channel;
    logic [CW-1:0] click_channel;
    logic [hist_pkg::SHIFT_WIDTH-1:0] shift_val;
    logic read_start;
    logic read_en;
    logic [HW-1:0] data_out;
    logic valid_out;
    logic last_out;

    entry_t table_q[$];
    logic [HW-1:0] model_hist [DEPTH];
    logic [HW-1:0] read_exp [DEPTH];
    logic [TW-1:0] start_m;
    logic [31:0] lfsr = 32'h0e66fe0b;
    bit configured = 1'b0;
    bit started_m = 1'b0;
    string read_name = "";
    int en_mode = 0;
    int rd_idx = DEPTH;
    int reads_planned = 0;
    int reads_issued = 0;
    int reads_done = 0;
    int cycle_cnt = 0;
    int cycle_limit = 1000000;

    tb_clock i_clock (.clk(clk), .rst(rst));

    histogram_top i_dut (
        .clk(clk), .rst(rst), .tagtime(tagtime), .channel(channel),
        .valid_tag(valid_tag), .config_en(config_en), .start_channel(start_channel),
        .click_channel(click_channel), .shift_val(shift_val), .read_start(read_start),
        .read_en(read_en), .data_out(data_out), .valid_out(valid_out),
        .last_out(last_out)
    );

    // fibonacci LFSR x^32 + x^22 + x^2 + x + 1, one new bit per step
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic int rand_bits(input int n);
        int v;
        v = 0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_step(lfsr);
            v = (v << 1) | int'(lfsr[0]);
        end
        return v;
    endfunction

    task automatic stop_run(input string msg);
        $display("%s", msg);
        $display("Test failed");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_count(input string name, input logic [HW-1:0] exp,
                               input logic [HW-1:0] act);
        if (act !== exp) begin
            stop_run($sformatf("Fail %s: expected %0d, actual %0d", name, exp, act));
        end
    endtask

    task automatic check_last(input string name, input bit exp, input logic act);
        if (act !== exp) begin
            stop_run($sformatf("Fail %s last: expected %0b, actual %0b", name, exp, act));
        end
    endtask

    // reference bin rule for one lane, lanes are fed in order 0 then 1
    task automatic model_lane(input logic [CW-1:0] ch, input logic [TW-1:0] t);
        logic [TW-1:0] diff;
        logic [TW-1:0] sh;
        if (ch == start_channel) begin
            started_m = 1'b1;
            start_m = t;
        end else if ((ch == click_channel) && started_m) begin
            diff = t - start_m;
            sh = diff >> shift_val;
            if (sh >= TW'(DEPTH)) begin
                model_hist[DEPTH-1]++;
            end else begin
                model_hist[sh[hist_pkg::HIST_ADDR_WIDTH-1:0]]++;
            end
        end
    endtask

    task automatic add_entry(input int kind, input int gap, input logic [NT-1:0] vld,
                             input logic [CW-1:0] ch0, input logic [TW-1:0] t0,
                             input logic [CW-1:0] ch1, input logic [TW-1:0] t1,
                             input string name);
        entry_t e;
        e = '{kind, gap, vld, ch0, t0, ch1, t1, name};
        table_q.push_back(e);
        if (kind == K_READ) begin
            reads_planned++;
        end
    endtask

    // start channel 3, click channel 5, bin width 4 time units
    task automatic build_table();
        int base;
        // tags during the clear sweep and while waiting for configuration
        add_entry(K_TAG, 2, 2'b11, 4'd3, 32'd100, 4'd5, 32'd140, "");
        add_entry(K_TAG, 70, 2'b11, 4'd3, 32'd200, 4'd5, 32'd260, "");
        // a start and a click arrive together with the configuration edge,
        // which is still before gathering begins
        add_entry(K_CFG, 4, 2'b11, 4'd3, 32'd2, 4'd5, 32'd200, "");
        add_entry(K_READ, 4, 2'b00, 4'd0, 32'd1, 4'd0, 32'd0, "empty");
        add_entry(K_WAIT, 0, 2'b00, 4'd0, 32'd0, 4'd0, 32'd0, "");
        // a click before any start and a tag on another channel come first
        add_entry(K_TAG, 3, 2'b11, 4'd5, 32'd50, 4'd7, 32'd60, "");
        add_entry(K_TAG, 0, 2'b01, 4'd3, 32'd1000, 4'd0, 32'd0, "");
        add_entry(K_TAG, 0, 2'b10, 4'd0, 32'd0, 4'd5, 32'd1012, "");
        add_entry(K_TAG, 0, 2'b11, 4'd5, 32'd1013, 4'd5, 32'd1014, "");
        add_entry(K_TAG, 0, 2'b11, 4'd5, 32'd1015, 4'd3, 32'd2000, "");
        add_entry(K_TAG, 0, 2'b11, 4'd5, 32'd2040, 4'd5, 32'd2041, "");
        add_entry(K_READ, 3, 2'b00, 4'd0, 32'd1, 4'd0, 32'd0, "pairs");
        add_entry(K_WAIT, 0, 2'b00, 4'd0, 32'd0, 4'd0, 32'd0, "");
        // overflow, an exact top bin, another channel and a wrapped difference
        add_entry(K_TAG, 3, 2'b01, 4'd5, 32'd3000, 4'd0, 32'd0, "");
        add_entry(K_TAG, 0, 2'b11, 4'd3, 32'd5000, 4'd7, 32'd5004, "");
        add_entry(K_TAG, 0, 2'b11, 4'd5, 32'd5252, 4'd5, 32'd5251, "");
        add_entry(K_TAG, 0, 2'b01, 4'd5, 32'd4999, 4'd0, 32'd0, "");
        add_entry(K_READ, 3, 2'b00, 4'd0, 32'd1, 4'd0, 32'd0, "range");
        add_entry(K_WAIT, 0, 2'b00, 4'd0, 32'd0, 4'd0, 32'd0, "");
        // lane 1 clicks against the start that lane 0 brings in the same cycle
        add_entry(K_TAG, 3, 2'b11, 4'd3, 32'd8000, 4'd5, 32'd8030, "");
        add_entry(K_TAG, 0, 2'b11, 4'd3, 32'd9000, 4'd5, 32'd9009, "");
        add_entry(K_READ, 3, 2'b00, 4'd0, 32'd1, 4'd0, 32'd0, "same_cycle");
        add_entry(K_WAIT, 0, 2'b00, 4'd0, 32'd0, 4'd0, 32'd0, "");
        // the two tags sent during this read belong to the next buffer
        add_entry(K_TAG, 3, 2'b11, 4'd3, 32'd10000, 4'd5, 32'd10016, "");
        add_entry(K_READ, 3, 2'b00, 4'd0, 32'd1, 4'd0, 32'd0, "pingpong");
        add_entry(K_TAG, 2, 2'b01, 4'd5, 32'd10024, 4'd0, 32'd0, "");
        add_entry(K_TAG, 0, 2'b10, 4'd0, 32'd0, 4'd5, 32'd10044, "");
        add_entry(K_WAIT, 0, 2'b00, 4'd0, 32'd0, 4'd0, 32'd0, "");
        // random pairs spread counts over many bins, then read_en stutters
        for (int i = 0; i < 24; i++) begin
            base = 20000 + i * 1000;
            add_entry(K_TAG, rand_bits(2), 2'b11, 4'd3, base, 4'd5, base + rand_bits(8), "");
        end
        add_entry(K_READ, 3, 2'b00, 4'd0, 32'd2, 4'd0, 32'd0, "random_en");
        add_entry(K_WAIT, 0, 2'b00, 4'd0, 32'd0, 4'd0, 32'd0, "");
    endtask

    task automatic drive_idle();
        valid_tag = '0;
        config_en = 1'b0;
        read_start = 1'b0;
    endtask

    // every entry is driven 1 ns after a rising edge, after gap idle cycles
    task automatic apply_entry(input entry_t e);
        repeat (e.gap) begin
            @(posedge clk);
            #1;
            drive_idle();
        end
        @(posedge clk);
        #1;
        drive_idle();
        case (e.kind)
            K_TAG: begin
                tagtime = {e.t1, e.t0};
                channel = {e.ch1, e.ch0};
                valid_tag = e.vld;
                if (configured && e.vld[0]) begin
                    model_lane(e.ch0, e.t0);
                end
                if (configured && e.vld[1]) begin
                    model_lane(e.ch1, e.t1);
                end
            end
            K_CFG: begin
                // tags sampled with the configuration edge never count
                tagtime = {e.t1, e.t0};
                channel = {e.ch1, e.ch0};
                valid_tag = e.vld;
                config_en = 1'b1;
                start_channel = e.ch0;
                click_channel = e.ch1;
                shift_val = e.t0[hist_pkg::SHIFT_WIDTH-1:0];
                configured = 1'b1;
            end
            K_READ: begin
                // the filled buffer is frozen here and gathering starts afresh
                read_start = 1'b1;
                en_mode = int'(e.t0);
                read_name = e.name;
                read_exp = model_hist;
                model_hist = '{default: '0};
                rd_idx = 0;
                reads_issued++;
            end
            default: begin
                wait (reads_done == reads_issued);
            end
        endcase
    endtask

    // read_en is always high in mode 1 and takes one LFSR bit in mode 2
    always @(posedge clk) begin
        #1;
        if (en_mode == 2) begin
            read_en = 1'(rand_bits(1));
        end else begin
            read_en = (en_mode == 1);
        end
    end

    // outputs are registered, so they are sampled on the falling edge
    always @(negedge clk) begin
        if (!rst && valid_out) begin
            if (rd_idx >= DEPTH) begin
                stop_run("valid_out came while no read was in progress");
            end
            check_count($sformatf("%s bin %0d", read_name, rd_idx), read_exp[rd_idx], data_out);
            check_last($sformatf("%s bin %0d", read_name, rd_idx), rd_idx == DEPTH - 1, last_out);
            rd_idx++;
            if (rd_idx == DEPTH) begin
                reads_done++;
            end
        end else if (!rst && last_out) begin
            stop_run("last_out came without valid_out");
        end
    end

    always @(posedge clk) begin
        cycle_cnt++;
        if (cycle_cnt > cycle_limit) begin
            stop_run($sformatf("timeout after %0d cycles, a read never finished", cycle_limit));
        end
    end

    initial begin
        int total;
        tagtime = '0;
        channel = '0;
        drive_idle();
        start_channel = '0;
        click_channel = '0;
        shift_val = '0;
        read_en = 1'b0;
        model_hist = '{default: '0};
        read_exp = '{default: '0};
        build_table();
        total = 0;
        foreach (table_q[i]) begin
            total += table_q[i].gap + 1;
        end
        cycle_limit = total + DEPTH * reads_planned * 4;
        @(negedge rst);
        foreach (table_q[i]) begin
            apply_entry(table_q[i]);
        end
        repeat (2) @(posedge clk);
        $display("Test passed");
        $finish;
    end

endmodule

// ==== tb/tb_clock.sv ====
// Testbench clock and reset
// Free-running 20 ns clock and a synchronous reset held for three cycles.

`timescale 1ns/1ps

module tb_clock (
    output logic clk,
    output logic rst
);

    localparam int RESET_CYCLES = 3;

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // reset drops just after the third rising edge
    initial begin
        rst = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        rst = 1'b0;
    end

endmodule
